/* common/lsu_pkg.sv */
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned LSU_XLEN  = 32;  // data and address width
  localparam int unsigned LSU_BE_W  = 4;   // byte lanes per bus word
  localparam int unsigned LSU_OFS_W = 2;   // byte offset inside a word

  ////////////////////////////////////////////////////////////////////////////
  // codes from the ex stage
  ////////////////////////////////////////////////////////////////////////////

  // access type, 11 decodes as byte too
  localparam logic [1:0] LSU_TYPE_WORD = 2'b00;
  localparam logic [1:0] LSU_TYPE_HALF = 2'b01;
  localparam logic [1:0] LSU_TYPE_BYTE = 2'b10;

  // extension of loaded bytes and halfwords
  localparam logic [1:0] LSU_EXT_ZERO = 2'b00;  // upper bits cleared
  localparam logic [1:0] LSU_EXT_SIGN = 2'b01;  // 11 behaves the same
  localparam logic [1:0] LSU_EXT_ONES = 2'b10;  // upper bits set

  ////////////////////////////////////////////////////////////////////////////
  // request controller
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] LSU_ST_IDLE              = 2'b00;  // free to request
  localparam logic [1:0] LSU_ST_WAIT_RVALID       = 2'b01;  // response pending
  localparam logic [1:0] LSU_ST_WAIT_RVALID_STALL = 2'b10;  // pending while ex stalls
  localparam logic [1:0] LSU_ST_IDLE_STALL        = 2'b11;  // done, ex still stalled

  // one bus word
  // lane 0 holds the lowest byte address
  typedef union packed {
    logic [LSU_BE_W-1:0][7:0]    b;  // byte lanes
    logic [LSU_BE_W/2-1:0][15:0] h;  // halfword lanes, h[0] is lanes 1:0
  } lsu_word_u;

endpackage

/* store/lsu_store_path.sv */
module lsu_store_path
(
  input  logic [lsu_pkg::LSU_XLEN-1:0]  operand_a_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  operand_b_i,
  input  logic                          addr_useincr_i,     // add operand b
  input  logic [1:0]                    data_type_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  data_wdata_i,
  input  logic [lsu_pkg::LSU_OFS_W-1:0] data_reg_offset_i,
  input  logic                          data_misaligned_i,  // this is the second part
  input  logic                          data_req_i,
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_addr_o,
  output logic [lsu_pkg::LSU_OFS_W-1:0] addr_ofs_o,
  output logic [lsu_pkg::LSU_BE_W-1:0]  data_be_o,
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_wdata_o,
  output logic                          data_misaligned_o
);
  import lsu_pkg::*;

  logic [LSU_OFS_W-1:0]  wdata_ofs;  // lanes to move the store data up by
  logic [2*LSU_XLEN-1:0] wdata_dbl;  // store word side by side with itself

  // effective address
  assign data_addr_o = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_ofs_o  = data_addr_o[LSU_OFS_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_i)
      LSU_TYPE_WORD:
      begin
        if (data_misaligned_i)
          data_be_o = (LSU_BE_W'(1) << addr_ofs_o) - LSU_BE_W'(1);  // low k lanes
        else
          data_be_o = {LSU_BE_W{1'b1}} << addr_ofs_o;  // lanes k and up
      end
      LSU_TYPE_HALF:
      begin
        if (data_misaligned_i)
          data_be_o = LSU_BE_W'(1);  // upper byte lands in lane 0
        else
          data_be_o = LSU_BE_W'(2'b11) << addr_ofs_o;  // top lane only at offset 3
      end
      LSU_TYPE_BYTE, 2'b11:
      begin
        data_be_o = LSU_BE_W'(1) << addr_ofs_o;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////////////////////////////////////////

  // register byte r must end up in lane k, so rotate by k - r lanes
  assign wdata_ofs = addr_ofs_o - data_reg_offset_i;  // wraps modulo 4

  // the upper half of the shifted pair is the rotated word
  assign wdata_dbl    = {data_wdata_i, data_wdata_i} << {wdata_ofs, 3'b000};
  assign data_wdata_o = wdata_dbl[2*LSU_XLEN-1:LSU_XLEN];

  // a first part that spills into the next word needs a second access
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i)
    begin
      if (data_type_i == LSU_TYPE_WORD)
        data_misaligned_o = (addr_ofs_o != '0);  // any offset but 0
      else if (data_type_i == LSU_TYPE_HALF)
        data_misaligned_o = (addr_ofs_o == '1);  // only offset 3 crosses
    end
  end

endmodule

/* load/lsu_load_path.sv */
module lsu_load_path
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  data_rdata_i,
  input  logic [1:0]                    data_type_i,
  input  logic [1:0]                    data_sign_ext_i,
  input  logic                          data_we_i,
  input  logic [lsu_pkg::LSU_OFS_W-1:0] addr_ofs_i,
  input  logic                          data_misaligned_ex_i,  // second part in ex
  input  logic                          data_misaligned_i,     // first part just detected
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_rdata_o
);
  import lsu_pkg::*;

  // attributes of the granted access
  logic [1:0]           data_type_q;
  logic [LSU_OFS_W-1:0] rdata_ofs_q;
  logic [1:0]           data_sign_ext_q;
  logic                 data_we_q;

  lsu_word_u            rdata_w;      // word on the bus this cycle
  lsu_word_u            rdata_q;      // held result or raw first half
  logic [LSU_XLEN-1:0]  rdata_w_asm;  // word, possibly spliced from two responses
  logic [15:0]          rdata_h_raw;  // selected halfword before extension
  logic [7:0]           rdata_b_raw;  // selected byte before extension
  logic                 h_fill;
  logic                 b_fill;
  logic [LSU_XLEN-1:0]  rdata_ext;

  // bit that fills the upper part of a short load
  function automatic logic ext_fill(input logic [1:0] mode, input logic msb);
    logic fill;
    case (mode)
      LSU_EXT_ZERO:        fill = 1'b0;
      LSU_EXT_ONES:        fill = 1'b1;
      LSU_EXT_SIGN, 2'b11: fill = msb;
    endcase
    return fill;
  endfunction

  // latch type, offset and mode when the bus takes the request
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q     <= LSU_TYPE_WORD;
      rdata_ofs_q     <= '0;
      data_sign_ext_q <= LSU_EXT_ZERO;
      data_we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      data_type_q     <= data_type_i;
      rdata_ofs_q     <= addr_ofs_i;
      data_sign_ext_q <= data_sign_ext_i;
      data_we_q       <= data_we_i;
    end
  end

  assign rdata_w = data_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // alignment
  ////////////////////////////////////////////////////////////////////////////

  // low lanes come from the new word, high lanes from the held first half
  always_comb
  begin
    case (rdata_ofs_q)
      2'd0:    rdata_w_asm = rdata_w;
      2'd1:    rdata_w_asm = {rdata_w.b[0], rdata_q.b[3], rdata_q.b[2], rdata_q.b[1]};
      2'd2:    rdata_w_asm = {rdata_w.h[0], rdata_q.h[1]};
      default: rdata_w_asm = {rdata_w.b[2], rdata_w.b[1], rdata_w.b[0], rdata_q.b[3]};
    endcase
  end

  always_comb
  begin
    case (rdata_ofs_q)
      2'd0:    rdata_h_raw = rdata_w.h[0];
      2'd1:    rdata_h_raw = {rdata_w.b[2], rdata_w.b[1]};
      2'd2:    rdata_h_raw = rdata_w.h[1];
      default: rdata_h_raw = {rdata_w.b[0], rdata_q.b[3]};  // crosses the word boundary
    endcase
  end

  assign rdata_b_raw = rdata_w.b[rdata_ofs_q];  // a byte never crosses

  ////////////////////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////////////////////

  assign h_fill = ext_fill(data_sign_ext_q, rdata_h_raw[15]);
  assign b_fill = ext_fill(data_sign_ext_q, rdata_b_raw[7]);

  always_comb
  begin
    case (data_type_q)
      LSU_TYPE_WORD:        rdata_ext = rdata_w_asm;
      LSU_TYPE_HALF:        rdata_ext = {{(LSU_XLEN-16){h_fill}}, rdata_h_raw};
      LSU_TYPE_BYTE, 2'b11: rdata_ext = {{(LSU_XLEN-8){b_fill}}, rdata_b_raw};
    endcase
  end

  // keep the raw word of a first half, otherwise the finished result
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !data_we_q)
    begin
      if (data_misaligned_ex_i || data_misaligned_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // live in the rvalid cycle, held copy afterwards
  assign data_rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

/* src/lsu_req_fsm.sv */
module lsu_req_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // ex stage wants a bus access
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic ex_valid_i,      // ex stage moves on this cycle
  output logic data_req_o,
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);
  import lsu_pkg::*;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       issue_ok;    // a new request may go out this cycle
  logic       granted;     // request accepted by the bus
  logic [1:0] state_gnt;   // where a granted request leads

  ////////////////////////////////////////////////////////////////////////////
  // request and ready levels
  ////////////////////////////////////////////////////////////////////////////

  // idle, or back to back in the cycle the pending response returns
  assign issue_ok = (state_q == LSU_ST_IDLE) ||
                    ((state_q == LSU_ST_WAIT_RVALID) && data_rvalid_i);

  assign data_req_o = issue_ok && data_req_ex_i;
  assign granted    = data_req_o && data_gnt_i;

  // ex waits while the bus holds off the grant
  assign lsu_ready_ex_o = !(data_req_o && !data_gnt_i);

  // wb waits for the outstanding response
  assign lsu_ready_wb_o = !((state_q == LSU_ST_WAIT_RVALID) && !data_rvalid_i);

  assign busy_o = (state_q != LSU_ST_IDLE) || data_req_o;

  // a stalled ex stage has not yet taken the request away
  assign state_gnt = ex_valid_i ? LSU_ST_WAIT_RVALID : LSU_ST_WAIT_RVALID_STALL;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LSU_ST_IDLE:
      begin
        if (granted)
          state_d = state_gnt;
      end
      LSU_ST_WAIT_RVALID:
      begin
        if (granted)
          state_d = state_gnt;       // next access already accepted
        else if (data_rvalid_i)
          state_d = LSU_ST_IDLE;     // done, or request still waiting for grant
      end
      LSU_ST_WAIT_RVALID_STALL:
      begin
        // no new request here, ex still holds the old one
        if (data_rvalid_i)
          state_d = ex_valid_i ? LSU_ST_IDLE : LSU_ST_IDLE_STALL;
        else if (ex_valid_i)
          state_d = LSU_ST_WAIT_RVALID;  // stall gone before the response
      end
      LSU_ST_IDLE_STALL:
      begin
        if (ex_valid_i)
          state_d = LSU_ST_IDLE;     // data is held, just wait out the stall
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= LSU_ST_IDLE;
    else
      state_q <= state_d;
  end

endmodule

/* src/lsu.sv */
module lsu
(
  input  logic                          clk,
  input  logic                          rst_n,

  // data bus
  output logic                          data_req_o,
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_addr_o,
  output logic                          data_we_o,
  output logic [lsu_pkg::LSU_BE_W-1:0]  data_be_o,
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_wdata_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  data_rdata_i,

  // ex stage side
  input  logic                          data_we_ex_i,
  input  logic [1:0]                    data_type_ex_i,        // word, half or byte
  input  logic [lsu_pkg::LSU_XLEN-1:0]  data_wdata_ex_i,
  input  logic [lsu_pkg::LSU_OFS_W-1:0] data_reg_offset_ex_i,  // byte offset in the register
  input  logic [1:0]                    data_sign_ext_ex_i,    // zero, sign or ones
  input  logic                          data_req_ex_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  operand_a_ex_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  operand_b_ex_i,
  input  logic                          addr_useincr_ex_i,     // address is a + b
  input  logic                          data_misaligned_ex_i,  // second part in flight
  input  logic                          ex_valid_i,
  output logic [lsu_pkg::LSU_XLEN-1:0]  data_rdata_ex_o,
  output logic                          data_misaligned_o,     // to the controller
  output logic                          lsu_ready_ex_o,
  output logic                          lsu_ready_wb_o,
  output logic                          busy_o
);
  import lsu_pkg::*;

  logic [LSU_OFS_W-1:0] addr_ofs;  // low address bits for read alignment

  assign data_we_o = data_we_ex_i;  // write enable goes straight to the bus

  // address, byte enables, write data, misalignment
  lsu_store_path u_store_path (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_addr_o       (data_addr_o),
    .addr_ofs_o        (addr_ofs),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .data_misaligned_o (data_misaligned_o)
  );

  // read alignment and extension
  lsu_load_path u_load_path (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_gnt_i           (data_gnt_i),
    .data_rvalid_i        (data_rvalid_i),
    .data_rdata_i         (data_rdata_i),
    .data_type_i          (data_type_ex_i),
    .data_sign_ext_i      (data_sign_ext_ex_i),
    .data_we_i            (data_we_ex_i),
    .addr_ofs_i           (addr_ofs),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rdata_o         (data_rdata_ex_o)
  );

  // bus request and stall control
  lsu_req_fsm u_req_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

/* verification/lsu_assert.sv */
module lsu_assert
(
  input logic                         clk,
  input logic                         rst_n,
  input logic                         req_i,
  input logic [lsu_pkg::LSU_XLEN-1:0] addr_i,
  input logic                         gnt_i,
  input logic                         rvalid_i,
  input logic                         busy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // address driven whenever a request is out
  req_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !$isunknown(addr_i))
    else $error("bus request with unknown address");

  gnt_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_i |-> req_i)                      // bus grants only a live request
    else $error("grant without request");

  rvalid_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> $past(busy_i))           // a response needs an access in flight
    else $error("rvalid while lsu was idle");

endmodule

bind lsu lsu_assert u_lsu_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_i    (data_req_o),
  .addr_i   (data_addr_o),
  .gnt_i    (data_gnt_i),
  .rvalid_i (data_rvalid_i),
  .busy_i   (busy_o)
);

/* verification/tb_lsu.sv */
module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int MAX_CYCLES = 6 * 40 * 8 + 4;  // tests x accesses x cycles plus reset

  logic        clk;
  logic        rst_n;
  logic        data_req_o, data_we_o, data_gnt_i;
  logic        data_rvalid_i = 1'b0;
  logic [31:0] data_rdata_i  = '0;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_ex_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic [1:0]  data_type_ex_i, data_reg_offset_ex_i, data_sign_ext_ex_i;
  logic        data_we_ex_i, data_req_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  logic        ex_valid_i;
  logic        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;

  lsu_word_u   mem [16];      // bus memory indexed by addr[5:2]
  lsu_word_u   ref_mem [16];  // expected contents kept byte by byte
  logic [1:0]  gnt_wait = '0; // cycles left before the next grant
  int          err_cnt  = 0;
  int          chk_cnt  = 0;
  int          cycles   = 0;

  lsu uut (.*);

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus model with a random grant delay and rvalid one cycle after grant
  ////////////////////////////////////////////////////////////////////////////

  assign data_gnt_i = data_req_o && (gnt_wait == 2'd0);  // grant only while requesting

  always @(posedge clk or negedge rst_n)
  begin : bus_model
    lsu_word_u word;
    int        l;
    if (!rst_n)
    begin
      gnt_wait      <= 2'd0;
      data_rvalid_i <= 1'b0;
    end
    else
    begin
      data_rvalid_i <= data_gnt_i;
      if (data_gnt_i)
      begin
        gnt_wait <= 2'($urandom_range(3, 0));  // delay for the next request
        word = mem[data_addr_o[5:2]];
        if (data_we_o)
        begin
          for (l = 0; l < 4; l++)
            if (data_be_o[l])
              word.b[l] = data_wdata_o[8*l +: 8];  // enabled lanes only
          mem[data_addr_o[5:2]] <= word;
        end
        else
          data_rdata_i <= word;
      end
      else if (data_req_o)
        gnt_wait <= gnt_wait - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////////////////////

  function automatic int acc_size(input logic [1:0] typ);
    case (typ)
      LSU_TYPE_WORD: return 4;
      LSU_TYPE_HALF: return 2;
      default:       return 1;
    endcase
  endfunction

  // lanes covered by the access or by its spill into the next word
  function automatic logic [3:0] lane_enables(input logic [1:0] ofs, input int size,
                                              input logic second);
    logic [3:0] be;
    int         l;
    for (l = 0; l < 4; l++)
      if (second)
        be[l] = (l + 4 < ofs + size);
      else
        be[l] = (l >= ofs) && (l < ofs + size);
    return be;
  endfunction

  // lane l carries register byte l - ofs + rofs
  function automatic logic [31:0] rotated_wdata(input logic [31:0] wd, input logic [1:0] ofs,
                                                input logic [1:0] rofs);
    lsu_word_u src;
    lsu_word_u res;
    int        l;
    src = wd;
    for (l = 0; l < 4; l++)
      res.b[l] = src.b[(l - ofs + rofs) & 3];
    return res;
  endfunction

  // gather the bytes from addr upwards and extend them
  function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [1:0] typ,
                                           input logic [1:0] ext);
    logic [31:0] a;
    logic [31:0] val;
    logic        fill;
    int          i;
    int          size;
    size = acc_size(typ);
    val  = '0;
    for (i = 0; i < size; i++)
    begin
      a = addr + i;
      val[8*i +: 8] = ref_mem[a[5:2]].b[a[1:0]];
    end
    if (size == 4)
      return val;
    case (ext)
      LSU_EXT_ZERO: fill = 1'b0;
      LSU_EXT_ONES: fill = 1'b1;
      default:      fill = val[8*size-1];  // sign and 11
    endcase
    for (i = 8 * size; i < 32; i++)
      val[i] = fill;
    return val;
  endfunction

  function automatic void ref_store(input logic [31:0] addr, input logic [1:0] typ,
                                    input logic [31:0] wd, input logic [1:0] rofs);
    logic [31:0] a;
    int          i;
    for (i = 0; i < acc_size(typ); i++)
    begin
      a = addr + i;
      ref_mem[a[5:2]].b[a[1:0]] = wd[8*((i + rofs) % 4) +: 8];
    end
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      $display("ERROR %0t: %s, got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // access tasks
  ////////////////////////////////////////////////////////////////////////////

  // drive one request and follow it to its grant
  task automatic issue(input logic we, input logic [1:0] typ, input logic [1:0] ext,
                       input logic [31:0] addr, input logic [31:0] wd,
                       input logic [1:0] rofs, input logic second);
    logic use_b;
    use_b = $urandom_range(1, 0);  // address as a alone or as a + b
    @(posedge clk);
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= we;
    data_type_ex_i       <= typ;
    data_sign_ext_ex_i   <= ext;
    data_wdata_ex_i      <= wd;
    data_reg_offset_ex_i <= rofs;
    data_misaligned_ex_i <= second;
    addr_useincr_ex_i    <= use_b;
    operand_a_ex_i       <= use_b ? addr - 32'd12 : addr;
    operand_b_ex_i       <= use_b ? 32'd12 : $urandom;
    do
    begin
      @(negedge clk);
      expect_equal(data_req_o, 1'b1, "request not held until grant");
      if (data_req_o && !data_gnt_i)
        expect_equal(lsu_ready_ex_o, 1'b0, "ex ready while grant pending");
    end
    while (!data_gnt_i);
    expect_equal(data_addr_o, addr, "bus address");
    expect_equal(data_be_o, lane_enables(addr[1:0], acc_size(typ), second), "byte enables");
    if (we)
      expect_equal(data_wdata_o, rotated_wdata(wd, addr[1:0], rofs), "write data");
    expect_equal(data_misaligned_o, !second && (addr[1:0] + acc_size(typ) > 4),
                 "misaligned flag");
    expect_equal(lsu_ready_ex_o, 1'b1, "ex ready in grant cycle");
  endtask

  // release the request, take the response and check the held load result
  task automatic finish_access(input logic we, output logic [31:0] rd);
    @(posedge clk);
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    do
      @(negedge clk);
    while (!data_rvalid_i);
    rd = data_rdata_ex_o;  // live in the rvalid cycle
    expect_equal(lsu_ready_wb_o, 1'b1, "wb ready with the response");
    @(negedge clk);
    if (!we)
      expect_equal(data_rdata_ex_o, rd, "held load data");
  endtask

  task automatic single_access(input logic we, input logic [1:0] typ, input logic [1:0] ext,
                               input logic [31:0] addr, input logic [31:0] wd,
                               input logic [1:0] rofs, output logic [31:0] rd);
    issue(we, typ, ext, addr, wd, rofs, 1'b0);
    finish_access(we, rd);
    if (we)
      ref_store(addr, typ, wd, rofs);
    else
      expect_equal(rd, load_ref(addr, typ, ext), "load data");
  endtask

  // first part and then the second part at the next word while the first is answered
  task automatic split_access(input logic we, input logic [1:0] typ, input logic [1:0] ext,
                              input logic [31:0] addr, input logic [31:0] wd);
    logic [31:0] rd;
    issue(we, typ, ext, addr, wd, 2'd0, 1'b0);
    issue(we, typ, ext, addr + 32'd4, wd, 2'd0, 1'b1);
    finish_access(we, rd);
    if (we)
      ref_store(addr, typ, wd, 2'd0);
    else
      expect_equal(rd, load_ref(addr, typ, ext), "assembled load data");
  endtask

  task automatic compare_memory();
    int i;
    for (i = 0; i < 16; i++)
      expect_equal(mem[i], ref_mem[i], "memory word");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic word_round_trip();
    logic [31:0] wd;
    logic [31:0] rd;
    int          e0;
    int          i;
    e0 = err_cnt;
    for (i = 0; i < 4; i++)
    begin
      wd = $urandom;
      single_access(1'b1, LSU_TYPE_WORD, LSU_EXT_ZERO, 32'(4 * i), wd, 2'd0, rd);
      single_access(1'b0, LSU_TYPE_WORD, LSU_EXT_ZERO, 32'(4 * i), 32'd0, 2'd0, rd);
      expect_equal(rd, wd, "word read back");
    end
    $display("aligned words: %0d errors", err_cnt - e0);
  endtask

  task automatic store_lane_sweep();
    logic [31:0] rd;
    int          e0;
    int          t;
    int          o;
    int          r;
    e0 = err_cnt;
    for (t = 0; t < 2; t++)
      for (o = 0; o < 4; o++)
        for (r = 0; r < 4; r++)
          if (t == 1 || o < 3)  // halfword at offset 3 is the misaligned case
            single_access(1'b1, t ? LSU_TYPE_BYTE : LSU_TYPE_HALF, LSU_EXT_ZERO,
                          32'(16 * t + 4 * r + o), $urandom, 2'(r), rd);
    compare_memory();
    $display("byte and halfword stores: %0d errors", err_cnt - e0);
  endtask

  task automatic load_extension_sweep();
    logic [31:0] rd;
    int          e0;
    int          t;
    int          o;
    int          e;
    e0 = err_cnt;
    for (t = 0; t < 2; t++)
      for (o = 0; o < 4; o++)
        for (e = 0; e < 4; e++)
          if (t == 1 || o < 3)
            single_access(1'b0, t ? LSU_TYPE_BYTE : LSU_TYPE_HALF, 2'(e),
                          32'(32 + 4 * e + o), 32'd0, 2'd0, rd);
    $display("load extension: %0d errors", err_cnt - e0);
  endtask

  task automatic misaligned_pairs();
    logic [1:0]  typ;
    logic [31:0] addr;
    int          e0;
    int          c;
    e0 = err_cnt;
    for (c = 0; c < 4; c++)
    begin
      typ  = (c == 3) ? LSU_TYPE_HALF : LSU_TYPE_WORD;
      addr = (c == 3) ? 32'd43 : 32'(40 + 4 * c + c + 1);  // word at offsets 1 to 3 and half at 3
      split_access(1'b1, typ, LSU_EXT_ZERO, addr, $urandom);
      split_access(1'b0, typ, LSU_EXT_SIGN, addr, 32'd0);
    end
    compare_memory();
    $display("misaligned accesses: %0d errors", err_cnt - e0);
  endtask

  task automatic ex_stall_hold();
    logic [31:0] rd;
    int          e0;
    e0 = err_cnt;
    @(posedge clk);
    ex_valid_i <= 1'b0;  // ex stalled at the grant
    single_access(1'b0, LSU_TYPE_WORD, LSU_EXT_ZERO, 32'h20, 32'd0, 2'd0, rd);
    expect_equal(busy_o, 1'b1, "busy after rvalid in stall");
    @(posedge clk);
    data_req_ex_i <= 1'b1;  // ex still asks but nothing may go out
    repeat (3)
    begin
      @(negedge clk);
      expect_equal(data_req_o, 1'b0, "request during stall");
      expect_equal(busy_o, 1'b1, "busy during stall");
    end
    @(posedge clk);
    ex_valid_i    <= 1'b1;
    data_req_ex_i <= 1'b0;
    @(negedge clk);
    expect_equal(busy_o, 1'b1, "busy in the cycle the stall ends");
    @(negedge clk);
    expect_equal(busy_o, 1'b0, "busy after the stall");
    $display("ex stall: %0d errors", err_cnt - e0);
  endtask

  task automatic random_mix();
    logic [31:0] rd;
    logic [31:0] addr;
    logic [1:0]  typ;
    int          e0;
    int          n;
    e0 = err_cnt;
    for (n = 0; n < 40; n++)
    begin
      typ = 2'($urandom_range(2, 0));
      if (typ == LSU_TYPE_WORD)
        addr = 32'(4 * $urandom_range(15, 0));
      else if (typ == LSU_TYPE_HALF)
        addr = 32'(2 * $urandom_range(31, 0));
      else
        addr = 32'($urandom_range(63, 0));
      single_access(1'($urandom_range(1, 0)), typ, 2'($urandom_range(3, 0)), addr,
                    $urandom, 2'($urandom_range(3, 0)), rd);
    end
    compare_memory();
    $display("back-pressure, random mix: %0d errors", err_cnt - e0);
  endtask

  initial
  begin
    lsu_word_u w;
    int        i;
    void'($urandom(90813));
    clk                  = 1'b0;
    rst_n                = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = LSU_TYPE_WORD;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i   = LSU_EXT_ZERO;
    data_req_ex_i        = 1'b0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i           = 1'b1;
    for (i = 0; i < 16; i++)
    begin
      w          = {8{4'(i)}} ^ 32'h8c3f_61d2;  // mixed sign bits in every word
      mem[i]     = w;
      ref_mem[i] = w;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal({data_req_o, busy_o, lsu_ready_ex_o, lsu_ready_wb_o}, 32'b0011,
                 "control levels after reset");
    expect_equal(data_rdata_ex_o, 32'd0, "read data after reset");
    word_round_trip();
    store_lane_sweep();
    load_extension_sweep();
    misaligned_pairs();
    ex_stall_hold();
    random_mix();
    $display("tests 6, checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* compile.f */
common/lsu_pkg.sv
store/lsu_store_path.sv
load/lsu_load_path.sv
src/lsu_req_fsm.sv
src/lsu.sv
verification/lsu_assert.sv
verification/tb_lsu.sv
